// ==== afifo_defs.svh ====
`ifndef AFIFO_DEFS_SVH
`define AFIFO_DEFS_SVH

// width of one data word
`define AFIFO_DATA_W 8

// memory address width, depth is 2**AFIFO_ADDR_W words
`define AFIFO_ADDR_W 4

`endif

// ==== src/afifo_pkg.sv ====
`include "afifo_defs.svh"

package afifo_pkg;

   // one stored word
   typedef logic [`AFIFO_DATA_W-1:0] data_t;

   // memory address, no wrap bit
   typedef logic [`AFIFO_ADDR_W-1:0] addr_t;

   // pointer in gray or binary form
   // top bit is the wrap bit, so full and empty can be told apart
   typedef logic [`AFIFO_ADDR_W:0] ptr_t;

   // fill count, 0 up to the full depth inclusive
   typedef logic [`AFIFO_ADDR_W:0] level_t;

   // gray to binary conversion
   // each binary bit is the xor of all gray bits at or above it
   function automatic ptr_t gray2bin(input ptr_t gray);
      ptr_t bin;
      bin[$bits(ptr_t)-1] = gray[$bits(ptr_t)-1];
      for (int i = $bits(ptr_t) - 2; i >= 0; i--) begin
         bin[i] = gray[i] ^ bin[i+1];
      end
      return bin;
   endfunction

endpackage

// ==== src/gray_counter.sv ====
`timescale 1ns/10ps

module gray_counter #(
   parameter int width = 5
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             en,
   output logic [width-1:0] bin_out,
   output logic [width-1:0] gray_out
);

   // runs one count ahead of bin_out
   logic [width-1:0] bin_next;

   // the gray register is loaded from the look-ahead count, so gray_out
   // always equals the gray code of bin_out and leaves straight from a flop
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bin_next <= width'(1);
         bin_out  <= '0;
         gray_out <= '0;
      end else if (en) begin
         bin_next <= bin_next + width'(1);
         bin_out  <= bin_next;
         gray_out <= bin_next ^ (bin_next >> 1);
      end
   end

endmodule

// ==== src/afifo_dp_mem.sv ====
`timescale 1ns/10ps

`include "afifo_defs.svh"

module afifo_dp_mem (
   input  logic                  wclk,
   input  logic                  we,
   input  afifo_pkg::addr_t      waddr,
   input  afifo_pkg::data_t      data_in,
   input  logic                  rclk,
   input  logic                  rst,
   input  logic                  re,
   input  afifo_pkg::addr_t      raddr,
   output afifo_pkg::data_t      data_out
);

   localparam int depth = 1 << `AFIFO_ADDR_W;

   // storage array
   afifo_pkg::data_t mem [depth];

   // write port
   always_ff @(posedge wclk) begin
      if (we) begin
         mem[waddr] <= data_in;
      end
   end

   // registered read port, holds between accepted reads
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         data_out <= '0;
      end else if (re) begin
         data_out <= mem[raddr];
      end
   end

endmodule

// ==== src/afifo_wr_ctrl.sv ====
`timescale 1ns/10ps

`include "afifo_defs.svh"

module afifo_wr_ctrl (
   input  logic                  wclk,
   input  logic                  rst,
   input  logic                  write_en,
   input  afifo_pkg::ptr_t       rptr,
   output afifo_pkg::ptr_t       wptr,
   output afifo_pkg::addr_t      waddr,
   output logic                  we,
   output logic                  full,
   output afifo_pkg::level_t     level_w
);

   localparam int depth = 1 << `AFIFO_ADDR_W;
   localparam int ptr_w = `AFIFO_ADDR_W + 1;

   // binary write count
   afifo_pkg::ptr_t wbin;

   // read pointer after two wclk flops
   afifo_pkg::ptr_t rptr_sync1;
   afifo_pkg::ptr_t rptr_sync2;

   // read count in write-domain binary
   afifo_pkg::ptr_t rbin_sync;

   // accepted write
   assign we = write_en & ~full;

   gray_counter #(
      .width    (ptr_w)
   ) u_wptr_cnt (
      .clk      (wclk),
      .rst      (rst),
      .en       (we),
      .bin_out  (wbin),
      .gray_out (wptr)
   );

   // low bits of the count address the memory
   assign waddr = wbin[`AFIFO_ADDR_W-1:0];

   // two-flop synchronizer, gray code keeps each step to one bit
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         rptr_sync1 <= '0;
         rptr_sync2 <= '0;
      end else begin
         rptr_sync1 <= rptr;
         rptr_sync2 <= rptr_sync1;
      end
   end

   assign rbin_sync = afifo_pkg::gray2bin(rptr_sync2);

   // wrap bit makes the modular difference span 0 to depth
   // a stale read count can only overstate the level, never understate it
   assign level_w = wbin - rbin_sync;

   assign full = (level_w == afifo_pkg::level_t'(depth));

endmodule

// ==== src/afifo_rd_ctrl.sv ====
`timescale 1ns/10ps

`include "afifo_defs.svh"

module afifo_rd_ctrl (
   input  logic                  rclk,
   input  logic                  rst,
   input  logic                  read_en,
   input  afifo_pkg::ptr_t       wptr,
   output afifo_pkg::ptr_t       rptr,
   output afifo_pkg::addr_t      raddr,
   output logic                  re,
   output logic                  empty,
   output afifo_pkg::level_t     level_r
);

   localparam int ptr_w = `AFIFO_ADDR_W + 1;

   // binary read count
   afifo_pkg::ptr_t rbin;

   // write pointer after two rclk flops
   afifo_pkg::ptr_t wptr_sync1;
   afifo_pkg::ptr_t wptr_sync2;

   // write count in read-domain binary
   afifo_pkg::ptr_t wbin_sync;

   // accepted read
   assign re = read_en & ~empty;

   gray_counter #(
      .width    (ptr_w)
   ) u_rptr_cnt (
      .clk      (rclk),
      .rst      (rst),
      .en       (re),
      .bin_out  (rbin),
      .gray_out (rptr)
   );

   // memory read address from the current count
   assign raddr = rbin[`AFIFO_ADDR_W-1:0];

   // bring the gray write pointer into rclk
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         wptr_sync1 <= '0;
         wptr_sync2 <= '0;
      end else begin
         wptr_sync1 <= wptr;
         wptr_sync2 <= wptr_sync1;
      end
   end

   assign wbin_sync = afifo_pkg::gray2bin(wptr_sync2);

   // lagging write count only makes the FIFO look emptier than it is
   assign level_r = wbin_sync - rbin;

   assign empty = (level_r == '0);

endmodule

// ==== src/afifo_top.sv ====
`timescale 1ns/10ps

module afifo_top (
   input  logic                  wclk,
   input  logic                  rclk,
   input  logic                  rst,
   input  logic                  write_en,
   input  afifo_pkg::data_t      data_in,
   input  logic                  read_en,
   output logic                  full,
   output afifo_pkg::level_t     level_w,
   output logic                  empty,
   output afifo_pkg::level_t     level_r,
   output afifo_pkg::data_t      data_out
);

   // gray pointers crossing between domains
   afifo_pkg::ptr_t  wptr;
   afifo_pkg::ptr_t  rptr;

   // memory side
   afifo_pkg::addr_t waddr;
   afifo_pkg::addr_t raddr;
   logic             we;
   logic             re;

   afifo_wr_ctrl u_wr_ctrl (
      .wclk     (wclk),
      .rst      (rst),
      .write_en (write_en),
      .rptr     (rptr),
      .wptr     (wptr),
      .waddr    (waddr),
      .we       (we),
      .full     (full),
      .level_w  (level_w)
   );

   afifo_rd_ctrl u_rd_ctrl (
      .rclk     (rclk),
      .rst      (rst),
      .read_en  (read_en),
      .wptr     (wptr),
      .rptr     (rptr),
      .raddr    (raddr),
      .re       (re),
      .empty    (empty),
      .level_r  (level_r)
   );

   afifo_dp_mem u_mem (
      .wclk     (wclk),
      .we       (we),
      .waddr    (waddr),
      .data_in  (data_in),
      .rclk     (rclk),
      .rst      (rst),
      .re       (re),
      .raddr    (raddr),
      .data_out (data_out)
   );

endmodule

// ==== bench/afifo_properties.sv ====
`timescale 1ns/10ps

`include "afifo_defs.svh"

module afifo_properties (
   input logic              wclk,
   input logic              rclk,
   input logic              rst,
   input logic              read_en,
   input logic              full,
   input afifo_pkg::level_t level_w,
   input logic              empty,
   input afifo_pkg::level_t level_r,
   input afifo_pkg::data_t  data_out
);

   localparam int depth = 1 << `AFIFO_ADDR_W;

   // number of assertion failures, read back by the testbench
   int fail_count = 0;

   // write side level never goes past the depth
   a_level_w_bound: assert property (@(posedge wclk) disable iff (rst)
      level_w <= afifo_pkg::level_t'(depth))
      else begin
         fail_count++;
         $error("level_w exceeds the FIFO depth");
      end

   a_full_flag: assert property (@(posedge wclk) disable iff (rst)
      full == (level_w == afifo_pkg::level_t'(depth)))
      else begin
         fail_count++;
         $error("full does not match level_w at depth");
      end

   a_level_r_bound: assert property (@(posedge rclk) disable iff (rst)
      level_r <= afifo_pkg::level_t'(depth))
      else begin
         fail_count++;
         $error("level_r exceeds the FIFO depth");
      end

   a_empty_flag: assert property (@(posedge rclk) disable iff (rst)
      empty == (level_r == '0))
      else begin
         fail_count++;
         $error("empty does not match a zero level_r");
      end

   // read on an empty FIFO leaves the output register alone
   a_underflow_hold: assert property (@(posedge rclk) disable iff (rst)
      (empty && read_en) |=> $stable(data_out))
      else begin
         fail_count++;
         $error("data_out changed after a read while empty");
      end

endmodule

bind afifo_top afifo_properties u_props (
   .wclk     (wclk),
   .rclk     (rclk),
   .rst      (rst),
   .read_en  (read_en),
   .full     (full),
   .level_w  (level_w),
   .empty    (empty),
   .level_r  (level_r),
   .data_out (data_out)
);

// ==== bench/afifo_tb.sv ====
`timescale 1ns/10ps

`include "afifo_defs.svh"

module afifo_tb;

   localparam int depth = 1 << `AFIFO_ADDR_W;

   // random traffic that is write heavy first and read heavy second
   localparam int phase_words = 750;
   localparam int wr_pct_a = 80;
   localparam int rd_pct_a = 55;
   localparam int wr_pct_b = 35;
   localparam int rd_pct_b = 85;

   // phase a is paced by the reader and phase b by the writer (wclk 8 ns, rclk 11 ns)
   localparam int est_rclk_cycles =
      (4 * depth + 32) +
      (phase_words * 100 / rd_pct_a) +
      (phase_words * 100 / wr_pct_b) * 8 / 11 +
      (2 * depth + 16);
   localparam int timeout_cycles = 4 * est_rclk_cycles;

   logic              wclk;
   logic              rclk;
   logic              rst;
   logic              write_en;
   logic              read_en;
   afifo_pkg::data_t  data_in;
   afifo_pkg::data_t  data_out;
   logic              full;
   logic              empty;
   afifo_pkg::level_t level_w;
   afifo_pkg::level_t level_r;

   // reference model
   afifo_pkg::data_t model_q[$];
   afifo_pkg::data_t expect_word;
   logic             check_pending;
   int               wr_accepted = 0;
   int               rd_accepted = 0;
   logic             writes_done = 1'b0;

   int data_errors = 0;
   int check_errors = 0;
   int other_errors = 0;
   int rd_cycles = 0;

   logic [31:0] wr_state;
   logic [31:0] rd_state;

   afifo_top DUT (
      .wclk     (wclk),
      .rclk     (rclk),
      .rst      (rst),
      .write_en (write_en),
      .data_in  (data_in),
      .read_en  (read_en),
      .full     (full),
      .level_w  (level_w),
      .empty    (empty),
      .level_r  (level_r),
      .data_out (data_out)
   );

   always #4 wclk = ~wclk;
   always #5.5 rclk = ~rclk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // 0 to 99 from the upper bits
   function automatic int roll_percent(input logic [31:0] s);
      return int'((s >> 16) % 32'd100);
   endfunction

   task automatic check_equal(input string name, input int got, input int expected);
      assert (got == expected) else begin
         check_errors++;
         $display("Fail %s: got %h, expected %h", name, got, expected);
      end
   endtask

   // model push uses the same acceptance rule as the write port
   always @(posedge wclk) begin
      if (!rst && write_en && !full) begin
         model_q.push_back(data_in);
         wr_accepted++;
      end
   end

   // model pop is compared against data_out half a cycle later
   always @(posedge rclk) begin
      afifo_pkg::data_t popped;
      if (rst) begin
         check_pending <= 1'b0;
      end else if (read_en && !empty) begin
         rd_accepted++;
         assert (model_q.size() > 0) else begin
            other_errors++;
            $display("read accepted while the model queue holds no word");
         end
         if (model_q.size() > 0) begin
            popped = model_q.pop_front();
            expect_word <= popped;
            check_pending <= 1'b1;
         end else begin
            check_pending <= 1'b0;
         end
      end else begin
         check_pending <= 1'b0;
      end
   end

   always @(negedge rclk) begin
      if (check_pending) begin
         assert (data_out == expect_word) else begin
            data_errors++;
            $display("Fail data_out: got %h, expected %h", data_out, expect_word);
         end
      end
   end

   always @(posedge rclk) begin
      rd_cycles++;
      if (rd_cycles >= timeout_cycles) begin
         other_errors++;
         $display("timeout: run did not complete within %0d rclk cycles", timeout_cycles);
         finish_run();
      end
   end

   task automatic finish_run();
      $display("errors: data %0d, checks %0d, other %0d, properties %0d",
               data_errors, check_errors, other_errors, DUT.u_props.fail_count);
      if (data_errors + check_errors + other_errors + DUT.u_props.fail_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   endtask

   // writes until the given number of words has been accepted
   task automatic run_writer(input int words, input int pct);
      int target;
      target = wr_accepted + words;
      @(negedge wclk);
      while (wr_accepted < target) begin
         wr_state = lcg_next(wr_state);
         write_en = (roll_percent(wr_state) < pct);
         wr_state = lcg_next(wr_state);
         data_in = afifo_pkg::data_t'(wr_state >> 16);
         @(negedge wclk);
      end
      write_en = 1'b0;
   endtask

   task automatic run_reader(input int pct);
      @(negedge rclk);
      while (!writes_done) begin
         rd_state = lcg_next(rd_state);
         read_en = (roll_percent(rd_state) < pct);
         @(negedge rclk);
      end
      read_en = 1'b0;
   endtask

   // read until the model holds no word
   task automatic drain_all();
      @(negedge rclk);
      read_en = 1'b1;
      while (model_q.size() != 0) begin
         @(negedge rclk);
      end
      read_en = 1'b0;
   endtask

   initial begin
      int               rd_before;
      afifo_pkg::data_t held;

      wclk = 1'b0;
      rclk = 1'b0;
      rst = 1'b1;
      write_en = 1'b0;
      read_en = 1'b0;
      data_in = '0;
      wr_state = 32'd35365;
      rd_state = lcg_next(32'd35365);

      repeat (2) @(negedge wclk);
      rst = 1'b0;

      check_equal("empty", int'(empty), 1);
      check_equal("full", int'(full), 0);
      check_equal("level_w", int'(level_w), 0);
      check_equal("level_r", int'(level_r), 0);
      check_equal("data_out", int'(data_out), 0);

      // fill past the depth so the extra words are dropped
      write_en = 1'b1;
      for (int i = 0; i < depth + 4; i++) begin
         wr_state = lcg_next(wr_state);
         data_in = afifo_pkg::data_t'(wr_state >> 16);
         @(negedge wclk);
      end
      write_en = 1'b0;
      check_equal("full", int'(full), 1);
      check_equal("level_w", int'(level_w), depth);
      check_equal("accepted writes", wr_accepted, depth);

      // drain returns exactly the first depth words
      drain_all();
      check_equal("empty", int'(empty), 1);
      check_equal("level_r", int'(level_r), 0);

      // reads while empty
      held = data_out;
      rd_before = rd_accepted;
      @(negedge rclk);
      read_en = 1'b1;
      repeat (6) @(negedge rclk);
      read_en = 1'b0;
      check_equal("data_out", int'(data_out), int'(held));
      check_equal("level_r", int'(level_r), 0);
      check_equal("accepted reads", rd_accepted - rd_before, 0);
      check_equal("full", int'(full), 0);
      check_equal("level_w", int'(level_w), 0);

      writes_done = 1'b0;
      fork
         begin
            run_writer(phase_words, wr_pct_a);
            writes_done = 1'b1;
         end
         run_reader(rd_pct_a);
      join

      writes_done = 1'b0;
      fork
         begin
            run_writer(phase_words, wr_pct_b);
            writes_done = 1'b1;
         end
         run_reader(rd_pct_b);
      join

      // pointers cross in 2 to 3 edges and then both levels match the model
      repeat (4) @(negedge rclk);
      check_equal("level_r", int'(level_r), model_q.size());
      check_equal("level_w", int'(level_w), model_q.size());

      drain_all();
      check_equal("empty", int'(empty), 1);
      check_equal("level_r", int'(level_r), 0);

      @(negedge rclk);
      finish_run();
   end

endmodule

// ==== afifo.f ====
+incdir+.
src/afifo_pkg.sv
src/gray_counter.sv
src/afifo_dp_mem.sv
src/afifo_wr_ctrl.sv
src/afifo_rd_ctrl.sv
src/afifo_top.sv
bench/afifo_properties.sv
bench/afifo_tb.sv

// ==== Makefile ====
# Verilator build and run for the dual-clock FIFO

VERILATOR ?= verilator
TOP       ?= afifo_tb
FILELIST  ?= afifo.f
OBJ_DIR   ?= obj_dir
SIM       ?= $(OBJ_DIR)/V$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

# sources from the file list plus the shared header
SOURCES := $(shell grep -v '^+' $(FILELIST)) afifo_defs.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) $(RUN_ARGS) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
